// ==== filelist.f ====
+incdir+include
source/conv_pkg.sv
source/conv_sram.sv
source/conv_ctrl.sv
source/pe_array.sv
source/ofm_stage.sv
source/conv_top.sv
test/conv_tb.sv

// ==== Bender.yml ====
package:
  name: conv_engine

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/conv_pkg.sv
      - source/conv_sram.sv
      - source/conv_ctrl.sv
      - source/pe_array.sv
      - source/ofm_stage.sv
      - source/conv_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/conv_tb.sv

// ==== test/conv_tb.sv ====
`timescale 1ns/1ns
`include "conv_macros.svh"

module conv_tb;

    localparam int XFER_CYC = 5;
    localparam int MAX_OUTW = 64;
    localparam int MAX_RUN = `CONV_MAX_KERNEL * MAX_OUTW + 4;
    localparam int N_RUNS = 7;
    localparam int N_XFER = `CONV_IFM_DEPTH + N_RUNS * (2 * MAX_OUTW + 8) + 40;
    localparam int TIMEOUT_CYC = 2 * (N_XFER * XFER_CYC + N_RUNS * MAX_RUN);

    logic                    clk;
    logic                    rst;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [`CONV_ADDR_W-1:0] paddr;
    logic [31:0]             pwdata;
    logic [31:0]             prdata;
    logic                    pready;
    logic                    pslverr;

    logic [31:0] lfsr = 32'he687_a0a8;
    int          errors = 0;
    int          cycles = 0;

    // model copies of buffer and config contents
    logic [31:0] ifm_m [`CONV_IFM_DEPTH];
    logic [31:0] wgt_m [`CONV_NUM_PE][`CONV_WGT_DEPTH];
    int          m_kw;
    int          m_outw;
    int          m_stride;
    int          m_shift;

    conv_top UUT (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYC) begin
            $display("simulation stopped at the cycle limit of %0d", TIMEOUT_CYC);
            $display("Test FAILED");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // convolution then shift and ReLU6 clamp per filter byte
    function automatic logic [31:0] expected_word(input int o);
        logic [31:0] w;
        int          acc;
        int          base;
        w = '0;
        base = o * m_stride;
        for (int f = 0; f < `CONV_NUM_PE; f++) begin
            acc = 0;
            for (int k = 0; k < m_kw; k++) begin
                for (int l = 0; l < `CONV_LANES; l++) begin
                    acc = acc + $signed(ifm_m[base + k][8*l +: 8]) *
                          $signed(wgt_m[f][k][8*l +: 8]);
                end
            end
            acc = acc >>> m_shift;
            if (acc < 0) begin
                acc = 0;
            end else if (acc > `CONV_RELU6_CAP) begin
                acc = `CONV_RELU6_CAP;
            end
            w[8*f +: 8] = acc[7:0];
        end
        return w;
    endfunction

    task automatic apb_xfer(input logic wr, input logic [`CONV_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        int waits;
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = wdata;
        @(negedge clk);
        penable = 1'b1;
        #5;
        waits = 0;
        while (!pready && waits < 3) begin
            @(negedge clk);
            #5;
            waits++;
        end
        if (!pready) begin
            $display("no pready from address 0x%03h after %0d wait states", addr, waits);
            errors++;
        end else if (waits != (wr ? 0 : 1)) begin
            $display("Fail %0t: address 0x%03h took %0d wait states", $time, addr, waits);
            errors++;
        end
        rdata = prdata;
        err = pslverr;
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic reg_write(input logic [`CONV_ADDR_W-1:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] unused;
        logic        err;
        apb_xfer(1'b1, addr, data, unused, err);
        if (err !== exp_err) begin
            $display("Fail %0t: write 0x%03h pslverr %b, expected %b", $time, addr, err, exp_err);
            errors++;
        end
    endtask

    task automatic reg_read(input logic [`CONV_ADDR_W-1:0] addr, output logic [31:0] data,
                            output logic err);
        apb_xfer(1'b0, addr, 32'd0, data, err);
    endtask

    task automatic ifm_store(input int i, input logic [31:0] data);
        ifm_m[i] = data;
        reg_write(`CONV_IFM_BASE + 12'(i * 4), data, 1'b0);
    endtask

    task automatic wgt_store(input int f, input int k, input logic [31:0] data);
        wgt_m[f][k] = data;
        reg_write(`CONV_WGT_BASE + 12'(f * 16 + k), data, 1'b0);
    endtask

    task automatic set_cfg(input int kw, input int outw, input int stride, input int shift);
        logic [31:0] word;
        word = {12'd0, 4'(shift), 2'd0, 2'(stride), 8'(outw), 4'(kw)};
        reg_write(`CONV_REG_CFG, word, 1'b0);
        m_kw = kw;
        m_outw = outw;
        m_stride = stride;
        m_shift = shift;
    endtask

    task automatic wait_done();
        logic [31:0] st;
        logic        err;
        int          polls;
        polls = 0;
        st = '0;
        while (st[1] !== 1'b1 && polls < MAX_RUN) begin
            reg_read(`CONV_REG_STATUS, st, err);
            polls++;
        end
        if (st[1] !== 1'b1 || st[0] !== 1'b0) begin
            $display("run did not finish, status 0x%08h after %0d polls", st, polls);
            errors++;
        end
    endtask

    task automatic check_ofm();
        logic [31:0] rd;
        logic [31:0] exp_w;
        logic        err;
        for (int o = 0; o < m_outw; o++) begin
            exp_w = expected_word(o);
            reg_read(`CONV_OFM_BASE + 12'(o * 4), rd, err);
            if (rd !== exp_w || err !== 1'b0) begin
                $display("Fail %0t: ofm[%0d] = 0x%08h, expected 0x%08h", $time, o, rd, exp_w);
                errors++;
            end
        end
    endtask

    task automatic check_read(input logic [`CONV_ADDR_W-1:0] addr, input logic [31:0] exp_d,
                              input logic exp_err);
        logic [31:0] rd;
        logic        err;
        reg_read(addr, rd, err);
        if (err !== exp_err || (!exp_err && rd !== exp_d)) begin
            $display("Fail %0t: read 0x%03h = 0x%08h err %b, expected 0x%08h err %b",
                     $time, addr, rd, err, exp_d, exp_err);
            errors++;
        end
    endtask

    initial begin
        logic [31:0] cfg_w;
        int          kw;
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // status after reset and config read back
        check_read(`CONV_REG_STATUS, 32'd0, 1'b0);
        repeat (4) begin
            cfg_w = rand_bits(32) & 32'h000f_3fff;
            reg_write(`CONV_REG_CFG, cfg_w, 1'b0);
            check_read(`CONV_REG_CFG, cfg_w, 1'b0);
        end

        // full runs with random data
        for (int i = 0; i < `CONV_IFM_DEPTH; i++) begin
            ifm_store(i, rand_bits(32));
        end
        repeat (4) begin
            for (int f = 0; f < `CONV_NUM_PE; f++) begin
                for (int k = 0; k < `CONV_WGT_DEPTH; k++) begin
                    wgt_store(f, k, rand_bits(32));
                end
            end
            kw = rand_bits(4);
            set_cfg(kw == 0 ? 1 : kw, rand_bits(6) + 1, rand_bits(2) % 3 + 1, 4 + rand_bits(3));
            reg_write(`CONV_REG_CTRL, 32'd1, 1'b0);
            wait_done();
            check_ofm();
        end

        // clamping with positive weights in f0 and f1 and negative in f2 and f3
        ifm_store(0, 32'h7f7f_7f7f);
        ifm_store(1, 32'h8080_8080);
        wgt_store(0, 0, 32'h7f7f_7f7f);
        wgt_store(1, 0, 32'h7f7f_7f7f);
        wgt_store(2, 0, 32'h8181_8181);
        wgt_store(3, 0, 32'h8181_8181);
        set_cfg(1, 2, 1, 0);
        reg_write(`CONV_REG_CTRL, 32'd1, 1'b0);
        wait_done();
        check_read(`CONV_OFM_BASE, 32'h0000_6060, 1'b0);
        check_read(`CONV_OFM_BASE + 12'd4, 32'h6060_0000, 1'b0);

        // error responses
        check_read(12'h00c, 32'd0, 1'b1);
        reg_write(12'h010, 32'h1234_5678, 1'b1);
        set_cfg(0, 4, 1, 0);
        reg_write(`CONV_REG_CTRL, 32'd1, 1'b1);
        set_cfg(15, 200, 3, 0);
        reg_write(`CONV_REG_CTRL, 32'd1, 1'b1);
        check_read(`CONV_REG_STATUS, 32'd2, 1'b0);
        check_read(`CONV_OFM_BASE, 32'h0000_6060, 1'b0);
        check_read(`CONV_OFM_BASE + 12'd4, 32'h6060_0000, 1'b0);

        // writes during a run are refused
        for (int k = 0; k < `CONV_WGT_DEPTH; k++) begin
            wgt_store(0, k, rand_bits(32));
        end
        set_cfg(15, 40, 2, 6);
        reg_write(`CONV_REG_CTRL, 32'd1, 1'b0);
        reg_write(`CONV_WGT_BASE + 12'd3, rand_bits(32), 1'b1);
        reg_write(`CONV_IFM_BASE + 12'd20, rand_bits(32), 1'b1);
        reg_write(`CONV_REG_CFG, 32'h0000_0011, 1'b1);
        wait_done();
        check_ofm();

        // back-to-back run with a new stride
        set_cfg(15, 40, 3, 6);
        reg_write(`CONV_REG_CTRL, 32'd1, 1'b0);
        wait_done();
        check_ofm();

        $display("checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== source/conv_top.sv ====
`timescale 1ns/1ns
`include "conv_macros.svh"

module conv_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`CONV_ADDR_W-1:0] paddr,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr
);
    import conv_pkg::*;

    localparam int IAW = $clog2(`CONV_IFM_DEPTH);
    localparam int WAW = $clog2(`CONV_WGT_DEPTH);
    localparam int OAW = $clog2(`CONV_OFM_DEPTH);

    logic                          ifm_we;
    logic [IAW-1:0]                ifm_waddr;
    logic [IAW-1:0]                ifm_raddr;
    conv_word_u                    ifm_wdata;
    conv_word_u                    ifm_rd;
    logic [`CONV_NUM_PE-1:0]       wgt_we;
    logic [WAW-1:0]                wgt_waddr;
    logic [WAW-1:0]                wgt_raddr;
    conv_word_u                    wgt_wdata;
    conv_word_u                    wgt_rd [`CONV_NUM_PE];
    logic                          acc_first;
    logic                          acc_last;
    logic signed [`CONV_ACC_W-1:0] sums [`CONV_NUM_PE];
    logic                          sum_valid;
    logic [OAW-1:0]                ofm_idx;
    logic                          ofm_we;
    logic [3:0]                    shift;
    logic [OAW-1:0]                ofm_raddr;
    conv_word_u                    ofm_rdata;

    conv_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .ifm_we    (ifm_we),
        .ifm_waddr (ifm_waddr),
        .ifm_raddr (ifm_raddr),
        .ifm_wdata (ifm_wdata),
        .wgt_we    (wgt_we),
        .wgt_waddr (wgt_waddr),
        .wgt_raddr (wgt_raddr),
        .wgt_wdata (wgt_wdata),
        .acc_first (acc_first),
        .acc_last  (acc_last),
        .ofm_idx   (ofm_idx),
        .ofm_we    (ofm_we),
        .shift     (shift),
        .ofm_raddr (ofm_raddr),
        .ofm_rdata (ofm_rdata)
    );

    conv_sram #(
        .DEPTH (`CONV_IFM_DEPTH)
    ) u_ifm_mem (
        .clk   (clk),
        .we    (ifm_we),
        .waddr (ifm_waddr),
        .raddr (ifm_raddr),
        .wdata (ifm_wdata),
        .rdata (ifm_rd)
    );

    // one weight bank per filter, all read at kernel index k
    genvar i;
    generate
        for (i = 0; i < `CONV_NUM_PE; i++) begin : g_wgt
            conv_sram #(
                .DEPTH (`CONV_WGT_DEPTH)
            ) u_wgt_mem (
                .clk   (clk),
                .we    (wgt_we[i]),
                .waddr (wgt_waddr),
                .raddr (wgt_raddr),
                .wdata (wgt_wdata),
                .rdata (wgt_rd[i])
            );
        end
    endgenerate

    pe_array u_pe (
        .clk       (clk),
        .rst       (rst),
        .ifm       (ifm_rd),
        .wgt       (wgt_rd),
        .acc_first (acc_first),
        .acc_last  (acc_last),
        .sums      (sums),
        .sum_valid (sum_valid)
    );

    ofm_stage u_ofm (
        .clk       (clk),
        .sums      (sums),
        .sum_valid (sum_valid),
        .shift     (shift),
        .ofm_idx   (ofm_idx),
        .ofm_we    (ofm_we),
        .ofm_raddr (ofm_raddr),
        .ofm_rdata (ofm_rdata)
    );

endmodule

// ==== source/ofm_stage.sv ====
`timescale 1ns/1ns
`include "conv_macros.svh"

module ofm_stage (
    input  logic                               clk,
    input  logic signed [`CONV_ACC_W-1:0]      sums [`CONV_NUM_PE],
    input  logic                               sum_valid,
    input  logic [3:0]                         shift,
    input  logic [$clog2(`CONV_OFM_DEPTH)-1:0] ofm_idx,
    input  logic                               ofm_we,
    input  logic [$clog2(`CONV_OFM_DEPTH)-1:0] ofm_raddr,
    output conv_pkg::conv_word_u               ofm_rdata
);
    import conv_pkg::*;

    conv_word_u q_word;

    // requantize to Q4.4 then ReLU6, one byte per filter
    always_comb begin
        logic signed [`CONV_ACC_W-1:0] scaled;

        q_word = '0;
        for (int f = 0; f < `CONV_NUM_PE; f++) begin
            scaled = sums[f] >>> shift;
            if (scaled < 0) begin
                q_word.lane[f] = 8'd0;
            end else if (scaled > `CONV_RELU6_CAP) begin
                q_word.lane[f] = 8'(`CONV_RELU6_CAP);
            end else begin
                q_word.lane[f] = scaled[7:0];
            end
        end
    end

    conv_sram #(
        .DEPTH (`CONV_OFM_DEPTH)
    ) u_ofm_mem (
        .clk   (clk),
        .we    (ofm_we),
        .waddr (ofm_idx),
        .raddr (ofm_raddr),
        .wdata (q_word),
        .rdata (ofm_rdata)
    );

    // write strobe comes from the sequencer delay line, sums from the pe array
    assert property (@(posedge clk) ofm_we === sum_valid)
        else $error("ofm write out of step with sum_valid");

endmodule

// ==== source/pe_array.sv ====
`timescale 1ns/1ns
`include "conv_macros.svh"

module pe_array (
    input  logic                          clk,
    input  logic                          rst,
    input  conv_pkg::conv_word_u          ifm,
    input  conv_pkg::conv_word_u          wgt [`CONV_NUM_PE],
    input  logic                          acc_first,
    input  logic                          acc_last,
    output logic signed [`CONV_ACC_W-1:0] sums [`CONV_NUM_PE],
    output logic                          sum_valid
);

    genvar i;

    generate
        for (i = 0; i < `CONV_NUM_PE; i++) begin : g_pe
            logic signed [`CONV_ACC_W-1:0] dot;
            logic signed [`CONV_ACC_W-1:0] acc_q;
            logic signed [`CONV_ACC_W-1:0] acc_next;

            // four-lane signed dot product
            always_comb begin
                dot = '0;
                for (int l = 0; l < `CONV_LANES; l++) begin
                    dot = dot + $signed(ifm.lane[l]) * $signed(wgt[i].lane[l]);
                end
            end

            assign acc_next = acc_first ? dot : acc_q + dot;

            // total leaves on acc_last so the next output can start at once
            always_ff @(posedge clk) begin
                acc_q <= acc_next;
                if (acc_last) begin
                    sums[i] <= acc_next;
                end
            end
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (rst) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= acc_last;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        sum_valid && !$past(acc_first && acc_last) |=> !sum_valid)
        else $error("sum_valid on back-to-back cycles with a multi-tap kernel");

endmodule

// ==== source/conv_ctrl.sv ====
`timescale 1ns/1ns
`include "conv_macros.svh"

module conv_ctrl (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [`CONV_ADDR_W-1:0]            paddr,
    input  logic [31:0]                        pwdata,
    output logic [31:0]                        prdata,
    output logic                               pready,
    output logic                               pslverr,
    output logic                               ifm_we,
    output logic [$clog2(`CONV_IFM_DEPTH)-1:0] ifm_waddr,
    output logic [$clog2(`CONV_IFM_DEPTH)-1:0] ifm_raddr,
    output conv_pkg::conv_word_u               ifm_wdata,
    output logic [`CONV_NUM_PE-1:0]            wgt_we,
    output logic [$clog2(`CONV_WGT_DEPTH)-1:0] wgt_waddr,
    output logic [$clog2(`CONV_WGT_DEPTH)-1:0] wgt_raddr,
    output conv_pkg::conv_word_u               wgt_wdata,
    output logic                               acc_first,
    output logic                               acc_last,
    output logic [$clog2(`CONV_OFM_DEPTH)-1:0] ofm_idx,
    output logic                               ofm_we,
    output logic [3:0]                         shift,
    output logic [$clog2(`CONV_OFM_DEPTH)-1:0] ofm_raddr,
    input  conv_pkg::conv_word_u               ofm_rdata
);
    import conv_pkg::*;

    localparam int IAW = $clog2(`CONV_IFM_DEPTH);
    localparam int WAW = $clog2(`CONV_WGT_DEPTH);
    localparam int OAW = $clog2(`CONV_OFM_DEPTH);
    localparam int AW = `CONV_ADDR_W;
    localparam logic [AW-1:0] REG_CTRL = `CONV_REG_CTRL;
    localparam logic [AW-1:0] REG_STATUS = `CONV_REG_STATUS;
    localparam logic [AW-1:0] REG_CFG = `CONV_REG_CFG;
    localparam logic [AW-1:0] IFM_BASE = `CONV_IFM_BASE;
    localparam logic [AW-1:0] WGT_BASE = `CONV_WGT_BASE;
    localparam logic [AW-1:0] OFM_BASE = `CONV_OFM_BASE;
    localparam logic [31:0] CFG_MASK = 32'h000f_3fff;

    logic            acc;
    logic            wr_acc;
    logic            rd_first;
    logic            rd_wait;
    logic            is_ctrl;
    logic            is_status;
    logic            is_cfg;
    logic            in_ifm;
    logic            in_wgt;
    logic            in_ofm;
    logic            hit;
    logic            wr_err;
    logic            wr_ok;
    logic            start;
    logic            rd_err_q;
    logic            rd_ofm_q;
    logic [31:0]     rd_data_q;
    logic [31:0]     cfg_q;
    logic [3:0]      kernel_w;
    logic [7:0]      out_w;
    logic [1:0]      stride;
    logic [10:0]     window;
    logic            cfg_ok;
    logic            busy;
    logic            done;
    logic            run;
    logic [OAW-1:0]  o_q;
    logic [WAW-1:0]  k_q;
    logic [IAW-1:0]  base_q;
    logic            issue_first;
    logic            issue_last;
    logic            issue_end;
    logic            end_d1;
    logic            end_d2;
    logic [OAW-1:0]  idx_d1;

    assign acc = psel && penable;
    assign wr_acc = acc && pwrite;
    assign rd_first = acc && !pwrite && !rd_wait;

    // address decode
    assign is_ctrl = paddr == REG_CTRL;
    assign is_status = paddr == REG_STATUS;
    assign is_cfg = paddr == REG_CFG;
    assign in_ifm = paddr[AW-1 -: 2] == IFM_BASE[AW-1 -: 2];
    assign in_wgt = paddr[AW-1 -: 2] == WGT_BASE[AW-1 -: 2];
    assign in_ofm = paddr[AW-1 -: 2] == OFM_BASE[AW-1 -: 2];
    assign hit = is_ctrl || is_status || is_cfg || in_ifm || in_ofm ||
                 (in_wgt && paddr[AW-3:6] == '0);

    assign kernel_w = cfg_q[`CONV_CFG_KW];
    assign out_w = cfg_q[`CONV_CFG_OUTW];
    assign stride = cfg_q[`CONV_CFG_STRIDE];
    assign shift = cfg_q[`CONV_CFG_SHIFT];

    // last ifm word touched plus one
    assign window = (11'(out_w) - 11'd1) * 11'(stride) + 11'(kernel_w);
    assign cfg_ok = kernel_w != 4'd0 && kernel_w <= `CONV_MAX_KERNEL && out_w != 8'd0 &&
                    stride != 2'd0 && window <= `CONV_IFM_DEPTH;

    always_comb begin
        wr_err = 1'b0;
        if (!hit || in_ofm) begin
            wr_err = 1'b1;
        end else if (busy && (in_ifm || in_wgt || is_cfg)) begin
            wr_err = 1'b1;
        end else if (is_ctrl && pwdata[0] && (busy || !cfg_ok)) begin
            wr_err = 1'b1;
        end
    end

    assign wr_ok = wr_acc && !wr_err;
    assign start = wr_ok && is_ctrl && pwdata[0];

    assign ifm_we = wr_ok && in_ifm;
    assign ifm_waddr = paddr[IAW+1:2];
    assign ifm_wdata = conv_word_u'(pwdata);
    assign wgt_we = (wr_ok && in_wgt) ? `CONV_NUM_PE'(1) << paddr[5:4] : '0;
    assign wgt_waddr = paddr[WAW-1:0];
    assign wgt_wdata = conv_word_u'(pwdata);
    assign ofm_raddr = paddr[OAW+1:2];

    // one wait state on every read
    assign pready = acc && (pwrite || rd_wait);
    assign pslverr = acc && (pwrite ? wr_err : (rd_wait && rd_err_q));
    assign prdata = rd_ofm_q ? ofm_rdata.raw : rd_data_q;

    always_ff @(posedge clk) begin
        if (rd_first) begin
            rd_err_q <= !hit;
            rd_ofm_q <= in_ofm;
            rd_data_q <= is_status ? {30'd0, done, busy} : (is_cfg ? cfg_q : 32'd0);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_q <= '0;
        end else if (wr_ok && is_cfg) begin
            cfg_q <= pwdata & CFG_MASK;
        end
    end

    assign issue_first = run && k_q == '0;
    assign issue_last = run && k_q == kernel_w - 4'd1;
    assign issue_end = issue_last && o_q == out_w - 8'd1;
    assign ifm_raddr = base_q + IAW'(k_q);
    assign wgt_raddr = k_q;

    // output loop outside, kernel loop inside
    always_ff @(posedge clk) begin
        if (rst) begin
            run <= 1'b0;
            busy <= 1'b0;
            done <= 1'b0;
            o_q <= '0;
            k_q <= '0;
            base_q <= '0;
        end else begin
            if (start) begin
                run <= 1'b1;
                busy <= 1'b1;
                done <= 1'b0;
                o_q <= '0;
                k_q <= '0;
                base_q <= '0;
            end else if (run) begin
                if (issue_last) begin
                    k_q <= '0;
                    o_q <= o_q + 1'b1;
                    base_q <= base_q + IAW'(stride);
                    if (issue_end) begin
                        run <= 1'b0;
                    end
                end else begin
                    k_q <= k_q + 1'b1;
                end
            end
            if (end_d2) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // flags follow memory, pe and ofm latency
    always_ff @(posedge clk) begin
        if (rst) begin
            acc_first <= 1'b0;
            acc_last <= 1'b0;
            ofm_we <= 1'b0;
            end_d1 <= 1'b0;
            end_d2 <= 1'b0;
            rd_wait <= 1'b0;
        end else begin
            acc_first <= issue_first;
            acc_last <= issue_last;
            ofm_we <= acc_last;
            end_d1 <= issue_end;
            end_d2 <= end_d1;
            rd_wait <= rd_first;
        end
    end

    always_ff @(posedge clk) begin
        idx_d1 <= o_q;
        ofm_idx <= idx_d1;
    end

    assert property (@(posedge clk) disable iff (rst) busy |-> !ifm_we && wgt_we == '0)
        else $error("buffer write enable raised during a run");

endmodule

// ==== source/conv_sram.sv ====
`timescale 1ns/1ns

module conv_sram #(
    parameter int DEPTH = 256
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    input  conv_pkg::conv_word_u     wdata,
    output conv_pkg::conv_word_u     rdata
);
    import conv_pkg::*;

    conv_word_u mem [DEPTH];

    // same-cycle read of a written address returns the old word
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

    assert property (@(posedge clk) we |-> (waddr < DEPTH))
        else $error("conv_sram write address %0d out of range", waddr);

endmodule

// ==== source/conv_pkg.sv ====
`include "conv_macros.svh"

package conv_pkg;

    // one buffer word, either whole or split into int8 channels
    typedef union packed {
        logic [31:0]                 raw;
        logic [`CONV_LANES-1:0][7:0] lane;
    } conv_word_u;

endpackage

// ==== include/conv_macros.svh ====
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// array sizes
`define CONV_NUM_PE      4
`define CONV_LANES       4
`define CONV_IFM_DEPTH   256
`define CONV_OFM_DEPTH   256
`define CONV_MAX_KERNEL  15
`define CONV_WGT_DEPTH   16
`define CONV_ACC_W       32

// Q4.4 value of 6.0
`define CONV_RELU6_CAP   96

// apb address map
`define CONV_ADDR_W      12
`define CONV_REG_CTRL    12'h000
`define CONV_REG_STATUS  12'h004
`define CONV_REG_CFG     12'h008
`define CONV_IFM_BASE    12'h400
`define CONV_WGT_BASE    12'h800
`define CONV_OFM_BASE    12'hC00

// cfg register fields
`define CONV_CFG_KW      3:0
`define CONV_CFG_OUTW    11:4
`define CONV_CFG_STRIDE  13:12
`define CONV_CFG_SHIFT   19:16

`endif
